// File: Bender.yml
package:
  name: ahb_output_stage

sources:
  - files:
      - src/ahb_pkg.sv
      - src/matrix_pkg.sv
      - src/output_arb.sv
      - src/addr_phase_mux.sv
      - src/data_phase_ctrl.sv
      - src/ahb_output_stage.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_ahb_output_stage.sv

// File: sim.f
src/ahb_pkg.sv
src/matrix_pkg.sv
src/output_arb.sv
src/addr_phase_mux.sv
src/data_phase_ctrl.sv
src/ahb_output_stage.sv
+incdir+tests
tests/tb_ahb_output_stage.sv

// File: src/addr_phase_mux.sv
// Address phase routing
`timescale 1ns/100ps

module addr_phase_mux
  import ahb_pkg::*;
  import matrix_pkg::*;
(
  input  port_in_s             i_ports [NUM_PORTS], // Bus-switch inputs
  input  grant_s               i_grant,       // Arbiter result
  output ahb_addr_s            o_addr,        // To slave and arbiter
  output logic [NUM_PORTS-1:0] o_active       // One-hot owner flags
);

  logic grant_ok;                             // Valid and in range

  assign grant_ok = i_grant.valid && (i_grant.idx < NUM_PORTS);

  // ------------------------------
  // Address phase mux
  // ------------------------------
  always_comb
  begin : p_addr_mux
    o_addr = '0;                              // hsel low, IDLE
    if (grant_ok)
      o_addr = i_ports[i_grant.idx].addr;     // Granted port drives slave
  end

  // ------------------------------
  // Active flag decode
  // ------------------------------
  always_comb
  begin : p_active_dec
    o_active = '0;
    if (grant_ok)
      o_active[i_grant.idx] = 1'b1;           // Tell input stage it owns slave
  end

endmodule

// File: src/ahb_output_stage.sv
// AHB matrix shared slave output stage
`timescale 1ns/100ps

module ahb_output_stage
  import ahb_pkg::*;
  import matrix_pkg::*;
(
  input  logic                 i_hclk,        // AHB clock
  input  logic                 HRESETn,       // Sync reset, active low
  input  port_in_s             i_ports [NUM_PORTS], // Bus-switch inputs
  input  logic                 i_hreadyoutm,  // HREADYOUTM from slave
  output logic [NUM_PORTS-1:0] o_active,      // Per port active flags
  output ahb_addr_s            o_slave_addr,  // HSELM, HADDRM, HTRANSM etc
  output hdata_t               o_hwdatam,     // HWDATAM
  output logic                 o_hreadymuxm   // HREADYMUXM
);

  logic [NUM_PORTS-1:0] req;                  // Arbiter requests
  grant_s               grant;                // Current owner

  // ------------------------------
  // Request forming
  // ------------------------------
  always_comb
  begin : p_req
    for (int p = 0; p < NUM_PORTS; p++)
      req[p] = i_ports[p].held_tran & i_ports[p].addr.hsel; // Pending and for us
  end

  // ------------------------------
  // Sub-blocks
  // ------------------------------
  output_arb u_output_arb
  (
    .i_hclk    (i_hclk),
    .i_hresetn (HRESETn),
    .i_req     (req),
    .i_ready   (o_hreadymuxm),                // Arbitrate on completed beats
    .i_addr    (o_slave_addr),                // Lock and burst feedback
    .o_grant   (grant)
  );

  addr_phase_mux u_addr_phase_mux
  (
    .i_ports  (i_ports),
    .i_grant  (grant),
    .o_addr   (o_slave_addr),
    .o_active (o_active)
  );

  data_phase_ctrl u_data_phase_ctrl
  (
    .i_hclk      (i_hclk),
    .i_hresetn   (HRESETn),
    .i_ports     (i_ports),
    .i_grant     (grant),
    .i_hsel      (o_slave_addr.hsel),
    .i_hreadyout (i_hreadyoutm),
    .o_hwdata    (o_hwdatam),
    .o_hready    (o_hreadymuxm)
  );

  // Stalled slave keeps the same input stage in charge
  a_active_stall : assert property (@(posedge i_hclk) disable iff (!HRESETn)
    !o_hreadymuxm |=> $stable(o_active));

endmodule

// File: src/ahb_pkg.sv
// AHB protocol types
package ahb_pkg;

  // ------------------------------
  // Bus widths
  // ------------------------------
  localparam int ADDR_W = 32;                 // Byte address width
  localparam int DATA_W = 32;                 // Write data width

  typedef logic [ADDR_W-1:0] haddr_t;         // HADDR
  typedef logic [DATA_W-1:0] hdata_t;         // HWDATA
  typedef logic [2:0]        hsize_t;         // HSIZE, bytes as log2
  typedef logic [3:0]        hprot_t;         // HPROT
  typedef logic [3:0]        hmaster_t;       // HMASTER id

  // ------------------------------
  // Transfer and burst encodings
  // ------------------------------
  typedef enum logic [1:0]
  {
    IDLE   = 2'b00,                           // No transfer
    BUSY   = 2'b01,                           // Burst paused by master
    NONSEQ = 2'b10,                           // First beat or single
    SEQ    = 2'b11                            // Later beats of a burst
  } htrans_e;

  typedef enum logic [2:0]
  {
    SINGLE = 3'b000,                          // One beat
    INCR   = 3'b001,                          // Undefined length
    WRAP4  = 3'b010,
    INCR4  = 3'b011,
    WRAP8  = 3'b100,
    INCR8  = 3'b101,
    WRAP16 = 3'b110,
    INCR16 = 3'b111
  } hburst_e;

  // Address phase as seen on one port or on the slave
  typedef struct packed
  {
    logic     hsel;                           // Slave select
    haddr_t   haddr;                          // Address
    htrans_e  htrans;                         // Transfer type
    logic     hwrite;                         // 1 for write
    hsize_t   hsize;                          // Transfer size
    hburst_e  hburst;                         // Burst type
    hprot_t   hprot;                          // Protection
    hmaster_t hmaster;                        // Master id
    logic     hmastlock;                      // Locked sequence
  } ahb_addr_s;

endpackage

// File: src/data_phase_ctrl.sv
// Data phase control
`timescale 1ns/100ps

module data_phase_ctrl
  import ahb_pkg::*;
  import matrix_pkg::*;
(
  input  logic     i_hclk,                    // AHB clock
  input  logic     i_hresetn,                 // Sync reset, active low
  input  port_in_s i_ports [NUM_PORTS],       // Bus-switch inputs
  input  grant_s   i_grant,                   // Address phase owner
  input  logic     i_hsel,                    // Muxed HSELM
  input  logic     i_hreadyout,               // Slave HREADYOUT
  output hdata_t   o_hwdata,                  // HWDATAM
  output logic     o_hready                   // HREADYMUXM
);

  grant_s data_grant;                         // Owner of data phase
  logic   slave_sel;                          // Slave in data phase
  logic   hready;                             // Internal ready

  // ------------------------------
  // Data phase registers
  // ------------------------------
  // Address phase moves to data phase on each completed transfer
  always_ff @(posedge i_hclk)
  begin : p_data_regs
    if (!i_hresetn)
    begin
      data_grant <= '0;
      slave_sel  <= 1'b0;                     // Ready idles high
    end
    else if (hready)
    begin
      data_grant <= i_grant;                  // Previous address phase port
      slave_sel  <= i_hsel;
    end
  end

  // ------------------------------
  // Write data mux
  // ------------------------------
  always_comb
  begin : p_wdata_mux
    o_hwdata = '0;
    if (data_grant.valid && (data_grant.idx < NUM_PORTS))
      o_hwdata = i_ports[data_grant.idx].hwdata; // Data from data phase owner
  end

  // ------------------------------
  // Ready generation
  // ------------------------------
  // Slave drives ready only while its data phase is in progress,
  // otherwise transfers elsewhere complete at once
  assign hready   = slave_sel ? i_hreadyout : 1'b1;
  assign o_hready = hready;

endmodule

// File: src/matrix_pkg.sv
// Bus matrix output stage types
package matrix_pkg;
  import ahb_pkg::*;

  // ------------------------------
  // Port count and indices
  // ------------------------------
  localparam int NUM_PORTS = 3;               // Bus-switch inputs per slave

  typedef logic [$clog2(NUM_PORTS)-1:0] port_idx_t; // Port 0 to 2

  // Registered arbitration result
  typedef struct packed
  {
    logic      valid;                         // A port holds the slave
    port_idx_t idx;                           // Which one
  } grant_s;

  // ------------------------------
  // Burst beat counting
  // ------------------------------
  typedef logic [3:0] beat_cnt_t;             // Beats still to come

  // Beats left after the NONSEQ of a fixed burst
  localparam beat_cnt_t BEATS4_LEFT  = 4'd3;
  localparam beat_cnt_t BEATS8_LEFT  = 4'd7;
  localparam beat_cnt_t BEATS16_LEFT = 4'd15;

  // ------------------------------
  // One bus-switch input
  // ------------------------------
  typedef struct packed
  {
    ahb_addr_s addr;                          // Address phase
    logic      held_tran;                     // Transfer pending in input stage
    hdata_t    hwdata;                        // Data phase write data
  } port_in_s;

endpackage

// File: src/output_arb.sv
// Round-robin output arbiter
`timescale 1ns/100ps

module output_arb
  import ahb_pkg::*;
  import matrix_pkg::*;
(
  input  logic                 i_hclk,        // AHB clock
  input  logic                 i_hresetn,     // Sync reset, active low
  input  logic [NUM_PORTS-1:0] i_req,         // Per port held_tran & hsel
  input  logic                 i_ready,       // HREADYMUXM
  input  ahb_addr_s            i_addr,        // Muxed address phase
  output grant_s               o_grant        // Registered grant
);

  grant_s    grant;                           // Current owner
  port_idx_t last_idx;                        // Last port granted
  logic      lock_hold;                       // Lock seen while selected
  logic      lock_hold_next;
  logic      lock_term;                       // Lock for arbitration
  beat_cnt_t beat_cnt;                        // Fixed burst beats left
  beat_cnt_t beat_next;
  logic      hold;                            // Keep current grant
  logic      found;                           // Some port requests
  port_idx_t pick;                            // Round-robin winner

  // ------------------------------
  // Lock tracking
  // ------------------------------
  // Master may leave this slave mid-sequence with hsel low; the flag keeps
  // the lock visible so no other port can slip in
  always_comb
  begin : p_lock_next
    lock_hold_next = lock_hold;               // Hold by default
    if (i_addr.hsel && (i_addr.htrans inside {NONSEQ, SEQ}) && i_addr.hmastlock)
      lock_hold_next = 1'b1;                  // Locked transfer started here
    else if (!i_addr.hmastlock)
      lock_hold_next = 1'b0;                  // Sequence over
  end

  assign lock_term = i_addr.hmastlock & (i_addr.hsel | lock_hold);

  // ------------------------------
  // Fixed burst beat counter
  // ------------------------------
  always_comb
  begin : p_beat_next
    beat_next = beat_cnt;
    case (i_addr.htrans)
      NONSEQ :
      begin
        beat_next = '0;                       // SINGLE, INCR or not for us
        if (i_addr.hsel)
        begin
          case (i_addr.hburst)
            WRAP4, INCR4   : beat_next = BEATS4_LEFT;
            WRAP8, INCR8   : beat_next = BEATS8_LEFT;
            WRAP16, INCR16 : beat_next = BEATS16_LEFT;
            default        : beat_next = '0;
          endcase
        end
      end
      SEQ :
      begin
        if (beat_cnt != '0)
          beat_next = beat_cnt - 1'b1;        // One beat done
      end
      BUSY    : beat_next = beat_cnt;         // Paused burst
      default : beat_next = '0;               // IDLE ends any burst
    endcase
  end

  // Beats still due after this edge keep the slave
  assign hold = lock_term | (beat_next != '0);

  // ------------------------------
  // Round-robin search
  // ------------------------------
  always_comb
  begin : p_rr_search
    int cand;
    found = 1'b0;
    pick  = '0;
    for (int i = 1; i <= NUM_PORTS; i++)
    begin
      cand = (int'(last_idx) + i) % NUM_PORTS; // Start after last winner
      if (!found && i_req[cand])
      begin
        found = 1'b1;
        pick  = port_idx_t'(cand);
      end
    end
  end

  // ------------------------------
  // State registers
  // ------------------------------
  always_ff @(posedge i_hclk)
  begin : p_arb_regs
    if (!i_hresetn)
    begin
      grant     <= '0;                        // No owner
      last_idx  <= port_idx_t'(NUM_PORTS - 1); // Port 0 searched first
      lock_hold <= 1'b0;
      beat_cnt  <= '0;
    end
    else if (i_ready)
    begin
      lock_hold <= lock_hold_next;
      beat_cnt  <= beat_next;
      if (!hold)
      begin
        grant.valid <= found;
        grant.idx   <= pick;
        if (found)
          last_idx <= pick;                   // Rotation point
      end
    end
  end

  assign o_grant = grant;

  // Mid-burst beats keep the owner
  a_burst_hold : assert property (@(posedge i_hclk) disable iff (!i_hresetn)
    (i_ready && (beat_cnt > beat_cnt_t'(1)) && (i_addr.htrans inside {SEQ, BUSY}))
    |=> $stable(grant));

endmodule

// File: tests/tb_steps.svh
// Output stage stimulus table
`ifndef TB_STEPS_SVH
`define TB_STEPS_SVH

// One table row, per port fields indexed by port number
typedef struct packed
{
  logic [2:0]      beh;                       // Behavior number
  logic [2:0]      hsel;                      // Per port hsel
  logic [2:0]      held;                      // Per port held_tran
  logic [2:0][1:0] trans;                     // Per port htrans code
  logic [2:0][2:0] burst;                     // Per port hburst code
  logic [2:0]      lock;                      // Per port hmastlock
  logic            hreadyout;                 // Slave HREADYOUTM
  logic [2:0]      exp_active;                // Expected active flags
  logic            exp_hsel;                  // Expected HSELM
  logic [1:0]      exp_port;                  // Address phase owner, 3 for none
  logic [1:0]      exp_dport;                 // Data phase owner, 3 for none
  logic            exp_ready;                 // Expected HREADYMUXM
} step_s;

localparam logic [5:0] ALL_NONSEQ = {NONSEQ, NONSEQ, NONSEQ};
localparam logic [8:0] ALL_SINGLE = {SINGLE, SINGLE, SINGLE};
localparam logic [8:0] P0_INCR4   = {SINGLE, SINGLE, INCR4}; // Burst on port 0 only

step_s steps [$];                             // Applied in order

task automatic load_steps();
  // Row layout
  // beh, hsel, held_tran, htrans {p2, p1, p0}, hburst {p2, p1, p0},
  // hmastlock, HREADYOUTM, active, HSELM, port, data port, HREADYMUXM

  // Nothing requests after reset
  steps.push_back(step_s'{3'd1, 3'b000, 3'b000, {IDLE, IDLE, IDLE}, ALL_SINGLE,
                          3'b000, 1'b1, 3'b000, 1'b0, NO_PORT, NO_PORT, 1'b1});
  // Port 2 alone
  steps.push_back(step_s'{3'd2, 3'b100, 3'b100, {NONSEQ, IDLE, IDLE}, ALL_SINGLE,
                          3'b000, 1'b1, 3'b100, 1'b1, 2'd2, NO_PORT, 1'b1});
  steps.push_back(step_s'{3'd2, 3'b100, 3'b000, {NONSEQ, IDLE, IDLE}, ALL_SINGLE,
                          3'b000, 1'b1, 3'b000, 1'b0, NO_PORT, 2'd2, 1'b1}); // Data phase
  // All three request singles
  steps.push_back(step_s'{3'd3, 3'b111, 3'b111, ALL_NONSEQ, ALL_SINGLE,
                          3'b000, 1'b1, 3'b001, 1'b1, 2'd0, NO_PORT, 1'b1});
  steps.push_back(step_s'{3'd3, 3'b111, 3'b111, ALL_NONSEQ, ALL_SINGLE,
                          3'b000, 1'b1, 3'b010, 1'b1, 2'd1, 2'd0, 1'b1});
  steps.push_back(step_s'{3'd3, 3'b111, 3'b111, ALL_NONSEQ, ALL_SINGLE,
                          3'b000, 1'b1, 3'b100, 1'b1, 2'd2, 2'd1, 1'b1});
  steps.push_back(step_s'{3'd3, 3'b111, 3'b111, ALL_NONSEQ, ALL_SINGLE,
                          3'b000, 1'b1, 3'b001, 1'b1, 2'd0, 2'd2, 1'b1}); // Wraps to 0
  // INCR4 on port 0, others waiting
  steps.push_back(step_s'{3'd4, 3'b111, 3'b111, ALL_NONSEQ, P0_INCR4,
                          3'b000, 1'b1, 3'b001, 1'b1, 2'd0, 2'd0, 1'b1});
  steps.push_back(step_s'{3'd4, 3'b111, 3'b111, {NONSEQ, NONSEQ, SEQ}, P0_INCR4,
                          3'b000, 1'b1, 3'b001, 1'b1, 2'd0, 2'd0, 1'b1});
  steps.push_back(step_s'{3'd4, 3'b111, 3'b111, {NONSEQ, NONSEQ, SEQ}, P0_INCR4,
                          3'b000, 1'b1, 3'b001, 1'b1, 2'd0, 2'd0, 1'b1});
  steps.push_back(step_s'{3'd4, 3'b111, 3'b110, {NONSEQ, NONSEQ, SEQ}, P0_INCR4,
                          3'b000, 1'b1, 3'b010, 1'b1, 2'd1, 2'd0, 1'b1}); // Last beat
  // Locked sequence on port 1
  steps.push_back(step_s'{3'd5, 3'b111, 3'b111, ALL_NONSEQ, ALL_SINGLE,
                          3'b010, 1'b1, 3'b010, 1'b1, 2'd1, 2'd1, 1'b1});
  steps.push_back(step_s'{3'd5, 3'b101, 3'b101, {NONSEQ, IDLE, NONSEQ}, ALL_SINGLE,
                          3'b010, 1'b1, 3'b010, 1'b0, 2'd1, 2'd1, 1'b1}); // hsel gap
  steps.push_back(step_s'{3'd5, 3'b111, 3'b111, ALL_NONSEQ, ALL_SINGLE,
                          3'b010, 1'b1, 3'b010, 1'b1, 2'd1, 2'd1, 1'b1});
  steps.push_back(step_s'{3'd5, 3'b111, 3'b101, ALL_NONSEQ, ALL_SINGLE,
                          3'b000, 1'b1, 3'b100, 1'b1, 2'd2, 2'd1, 1'b1}); // Lock released
  // Slave stalls with port 2 in address phase
  steps.push_back(step_s'{3'd6, 3'b101, 3'b101, {NONSEQ, IDLE, NONSEQ}, ALL_SINGLE,
                          3'b000, 1'b0, 3'b100, 1'b1, 2'd2, 2'd1, 1'b0});
  steps.push_back(step_s'{3'd6, 3'b101, 3'b101, {NONSEQ, IDLE, NONSEQ}, ALL_SINGLE,
                          3'b000, 1'b0, 3'b100, 1'b1, 2'd2, 2'd1, 1'b0});
  steps.push_back(step_s'{3'd6, 3'b101, 3'b101, {NONSEQ, IDLE, NONSEQ}, ALL_SINGLE,
                          3'b000, 1'b1, 3'b001, 1'b1, 2'd0, 2'd2, 1'b1}); // Stall over
endtask

`endif

// File: tests/tb_ahb_output_stage.sv
// Output stage testbench
`timescale 1ns/100ps

module tb_ahb_output_stage
  import ahb_pkg::*;
  import matrix_pkg::*;
();

  localparam int         READY_TIMEOUT = 20;  // Cycles allowed for ready to rise
  localparam logic [1:0] NO_PORT       = 2'd3; // Table code for no owner

  logic                 clk = 1'b0;
  logic                 hresetn;
  port_in_s             ports [NUM_PORTS];    // Bus-switch inputs to DUT
  logic                 hreadyoutm;
  logic [NUM_PORTS-1:0] active;
  ahb_addr_s            slave_addr;
  hdata_t               hwdatam;
  logic                 hreadymuxm;

  haddr_t port_addr  [NUM_PORTS];             // Fixed random address per port
  hdata_t port_wdata [NUM_PORTS];             // Fixed random write data per port
  int     cur_row;
  int     checks;
  int     errors;
  int     beh_errors;                         // Errors in current behavior

  `include "tb_steps.svh"

  always #2 clk = ~clk;                       // 4 ns period

  ahb_output_stage ahb_output_stage_i
  (
    .i_hclk       (clk),
    .HRESETn      (hresetn),
    .i_ports      (ports),
    .i_hreadyoutm (hreadyoutm),
    .o_active     (active),
    .o_slave_addr (slave_addr),
    .o_hwdatam    (hwdatam),
    .o_hreadymuxm (hreadymuxm)
  );

  // ------------------------------
  // Drive and check
  // ------------------------------
  task automatic drive_step(input step_s s);
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      ports[p].addr.hsel      = s.hsel[p];
      ports[p].addr.haddr     = port_addr[p];
      ports[p].addr.htrans    = htrans_e'(s.trans[p]);
      ports[p].addr.hwrite    = 1'b1;
      ports[p].addr.hsize     = 3'b010;       // Word
      ports[p].addr.hburst    = hburst_e'(s.burst[p]);
      ports[p].addr.hprot     = 4'b0011;
      ports[p].addr.hmaster   = hmaster_t'(p);
      ports[p].addr.hmastlock = s.lock[p];
      ports[p].held_tran      = s.held[p];
      ports[p].hwdata         = port_wdata[p];
    end
    hreadyoutm = s.hreadyout;
  endtask

  task automatic compare(input string name, input logic [63:0] exp_val,
                         input logic [63:0] got);
    checks++;
    assert (got === exp_val)
    else
    begin
      $display("FAILED %s row %0d expected 0x%h got 0x%h", name, cur_row, exp_val, got);
      errors++;
      beh_errors++;
    end
  endtask

  task automatic check_step(input step_s s);
    logic [1:0] htrans_exp;
    haddr_t     haddr_exp;
    hdata_t     wdata_exp;
    ahb_addr_s  addr_exp;
    htrans_exp = IDLE;                        // No owner drives zeros
    haddr_exp  = '0;
    wdata_exp  = '0;
    addr_exp   = '0;
    if (s.exp_port != NO_PORT)
    begin
      htrans_exp = s.trans[s.exp_port];
      haddr_exp  = port_addr[s.exp_port];
      addr_exp   = ports[s.exp_port].addr;    // Whole address phase of the owner
    end
    if (s.exp_dport != NO_PORT)
      wdata_exp = port_wdata[s.exp_dport];    // Previous address phase owner
    compare("o_active", s.exp_active, active);
    compare("HSELM", s.exp_hsel, slave_addr.hsel);
    compare("HTRANSM", htrans_exp, slave_addr.htrans);
    compare("HADDRM", haddr_exp, slave_addr.haddr);
    compare("o_slave_addr", addr_exp, slave_addr);
    compare("HWDATAM", wdata_exp, hwdatam);
    compare("HREADYMUXM", s.exp_ready, hreadymuxm);
  endtask

  function automatic string behavior_name(input int beh);
    case (beh)
      1       : return "reset state";
      2       : return "single requester";
      3       : return "round-robin order";
      4       : return "fixed-burst hold";
      5       : return "lock hold";
      6       : return "back-pressure";
      default : return "unknown";
    endcase
  endfunction

  task automatic report_behavior(input int beh);
    if (beh_errors == 0)
      $display("Behavior %0d, %s: passed", beh, behavior_name(beh));
    else
      $display("Behavior %0d, %s: %0d errors", beh, behavior_name(beh), beh_errors);
    beh_errors = 0;
  endtask

  task automatic wait_ready(input string where);
    int cycles;
    cycles = 0;
    while ((hreadymuxm !== 1'b1) && (cycles < READY_TIMEOUT))
    begin
      @(negedge clk);
      cycles++;
    end
    if (hreadymuxm !== 1'b1)
    begin
      $display("Timeout: HREADYMUXM did not rise %s", where);
      errors++;
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial
  begin : p_main
    step_s idle;
    void'($urandom(63958));                   // Single seed for the run
    checks     = 0;
    errors     = 0;
    beh_errors = 0;
    cur_row    = 0;
    for (int p = 0; p < NUM_PORTS; p++)
    begin
      port_addr[p]  = $urandom();
      port_wdata[p] = $urandom();
    end
    idle           = '0;                      // IDLE, SINGLE, nothing selected
    idle.hreadyout = 1'b1;
    hresetn        = 1'b0;
    drive_step(idle);
    hreadyoutm     = 1'b0;                    // Unselected slave must not stall
    load_steps();

    repeat (3) @(posedge clk);                // Reset for three cycles
    @(negedge clk);
    hresetn = 1'b1;
    wait_ready("after reset");
    check_step(steps[0]);                     // Reset state before any edge

    for (int r = 0; r < steps.size(); r++)
    begin
      cur_row = r;
      drive_step(steps[r]);                   // On falling edge
      @(posedge clk);
      #1;                                     // Settled before next falling edge
      check_step(steps[r]);
      if ((r == steps.size() - 1) || (steps[r + 1].beh != steps[r].beh))
        report_behavior(steps[r].beh);
      @(negedge clk);
    end

    drive_step(idle);
    wait_ready("after the last step");
    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0)
      $display("TEST OK");
    else
      $display("TEST FAILED");
    $finish;
  end

endmodule
